//--- design/lsqGeometryPkg.sv
// load/store queue geometry
// field widths for addresses, register tags and active-list IDs,
// plus the default queue depth and lane counts used at the top level
package lsqGeometryPkg;

	// virtual address, one full word
	localparam int virtAddrWidth = 32;

	// byte offset bits inside a word
	localparam int byteOffsetWidth = 2;

	// physical register tag
	localparam int phyRegWidth = 7;

	// active-list entry ID
	localparam int alIdWidth = 7;

	// load queue entries, need not be a power of two
	localparam int defaultLsqDepth = 16;

	// lanes per cycle
	localparam int defaultDispatchWidth = 2;
	localparam int defaultCommitWidth = 2;

endpackage

//--- design/memAccessPkg.sv
// memory access encodings
// access size codes and the per-entry load payload record
package memAccessPkg;

	// wider access gets the larger code
	// the violation check relies on this ordering
	typedef enum logic [1:0]
	{
		accessByte = 2'd0,
		accessHalf = 2'd1,
		accessWord = 2'd2
	} accessSizeT;

	// payload kept per load entry
	// the replay path reads the head, the violation path reads the first match
	typedef struct packed
	{
		// destination register of the load
		logic [lsqGeometryPkg::phyRegWidth-1:0] phyDest;
		// active-list slot, flagged on a violation
		logic [lsqGeometryPkg::alIdWidth-1:0] alId;
		// full virtual address incl. byte offset
		logic [lsqGeometryPkg::virtAddrWidth-1:0] addr;
	} ldPayloadT;

endpackage

//--- design/loadAddrCam.sv
// load address CAM
// one tag per load entry, one indexed write port and one parallel
// match port that returns a hit bit per entry
`timescale 1ns/1ps

module loadAddrCam
#(
	parameter int lsqDepth = lsqGeometryPkg::defaultLsqDepth,
	parameter int tagWidth = 1,
	localparam int idxWidth = (lsqDepth > 1) ? $clog2(lsqDepth) : 1
)
(
	input  logic                clk,
	input  logic                we_i,
	input  logic [idxWidth-1:0] wrIdx_i,
	input  logic [tagWidth-1:0] wrTag_i,
	input  logic [tagWidth-1:0] matchTag_i,
	output logic [lsqDepth-1:0] hit_o
);

	// tag storage, contents only matter once the entry is valid
	logic [tagWidth-1:0] tagQ [lsqDepth];

	// write from the load execute port
	always_ff @(posedge clk)
	begin
		if (we_i)
		begin
			tagQ[wrIdx_i] <= wrTag_i;
		end
	end

	// compare every entry against the probe
	always_comb
	begin
		for (int i = 0; i < lsqDepth; i++)
		begin
			hit_o[i] = (tagQ[i] == matchTag_i);
		end
	end

endmodule

//--- design/ldqRegFile.sv
// load queue register file
// generic storage for one entry type with several combinational read
// ports and several write ports, the highest write lane wins a collision
`timescale 1ns/1ps

module ldqRegFile
#(
	parameter type entryT = logic,
	parameter int lsqDepth = lsqGeometryPkg::defaultLsqDepth,
	parameter int numRead = 1,
	parameter int numWrite = 1,
	localparam int idxWidth = (lsqDepth > 1) ? $clog2(lsqDepth) : 1
)
(
	input  logic                clk,
	input  logic [idxWidth-1:0] rdIdx_i  [numRead],
	output entryT               rdData_o [numRead],
	input  logic [numWrite-1:0] we_i,
	input  logic [idxWidth-1:0] wrIdx_i  [numWrite],
	input  entryT               wrData_i [numWrite]
);

	entryT memQ [lsqDepth];

	// lanes in order, so a later lane overrides an earlier one
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < numWrite; w++)
		begin
			if (we_i[w])
			begin
				memQ[wrIdx_i[w]] <= wrData_i[w];
			end
		end
	end

	// asynchronous reads
	// writes become visible after the edge
	always_comb
	begin
		for (int r = 0; r < numRead; r++)
		begin
			rdData_o[r] = memQ[rdIdx_i[r]];
		end
	end

endmodule

//--- design/ldqStatus.sv
// load queue status bits
// per-entry address-valid, written-back and size state with set/clear
// priority, commit lane decode and the head replay decision
`timescale 1ns/1ps

module ldqStatus
#(
	parameter int lsqDepth = lsqGeometryPkg::defaultLsqDepth,
	parameter int dispatchWidth = lsqGeometryPkg::defaultDispatchWidth,
	parameter int commitWidth = lsqGeometryPkg::defaultCommitWidth,
	localparam int idxWidth = (lsqDepth > 1) ? $clog2(lsqDepth) : 1,
	localparam int commitCntWidth = $clog2(commitWidth + 1)
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     recoverFlag_i,

	input  logic                     ldValid_i,
	input  logic [idxWidth-1:0]      ldLsqId_i,
	input  memAccessPkg::accessSizeT ldSize_i,
	input  logic                     loadDataValid_i,

	input  logic                     dispatchReady_i,
	input  logic [dispatchWidth-1:0] dispLoad_i,
	input  logic [idxWidth-1:0]      dispLdId_i [dispatchWidth],

	input  logic [commitCntWidth-1:0] commitLdCount_i,
	input  logic [idxWidth-1:0]      commitLdIndex_i [commitWidth],
	input  logic [idxWidth-1:0]      ldqHead_i,

	output logic [lsqDepth-1:0]      addrValid_o,
	output logic [lsqDepth-1:0]      writtenBack_o,
	output memAccessPkg::accessSizeT entrySize_o [lsqDepth],
	output logic                     replayValid_o,
	output memAccessPkg::accessSizeT replaySize_o
);

	logic [lsqDepth-1:0] addrValidQ;
	logic [lsqDepth-1:0] writtenBackQ;
	memAccessPkg::accessSizeT sizeQ [lsqDepth];

	// count to thermometer, lane c retires when c < count
	logic [commitWidth-1:0] commitLaneEn;

	always_comb
	begin
		for (int c = 0; c < commitWidth; c++)
		begin
			commitLaneEn[c] = (c < int'(commitLdCount_i));
		end
	end

	// recovery beats everything
	// dispatch and commit clears come after the execute set so they win
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addrValidQ <= '0;
			writtenBackQ <= '0;
			for (int i = 0; i < lsqDepth; i++)
			begin
				sizeQ[i] <= memAccessPkg::accessByte;
			end
		end
		else if (recoverFlag_i)
		begin
			addrValidQ <= '0;
			writtenBackQ <= '0;
			for (int i = 0; i < lsqDepth; i++)
			begin
				sizeQ[i] <= memAccessPkg::accessByte;
			end
		end
		else
		begin
			// new or replayed load has its address now
			if (ldValid_i)
			begin
				addrValidQ[ldLsqId_i] <= 1'b1;
				writtenBackQ[ldLsqId_i] <= loadDataValid_i;
				sizeQ[ldLsqId_i] <= ldSize_i;
			end

			// freshly dispatched loads start empty
			if (dispatchReady_i)
			begin
				for (int k = 0; k < dispatchWidth; k++)
				begin
					if (dispLoad_i[k])
					begin
						addrValidQ[dispLdId_i[k]] <= 1'b0;
						writtenBackQ[dispLdId_i[k]] <= 1'b0;
					end
				end
			end

			// retiring loads
			for (int c = 0; c < commitWidth; c++)
			begin
				if (commitLaneEn[c])
				begin
					addrValidQ[commitLdIndex_i[c]] <= 1'b0;
					writtenBackQ[commitLdIndex_i[c]] <= 1'b0;
				end
			end
		end
	end

	assign addrValid_o = addrValidQ;
	assign writtenBack_o = writtenBackQ;
	assign entrySize_o = sizeQ;

	// head has an address but no data yet, so offer it again
	assign replayValid_o = addrValidQ[ldqHead_i] & ~writtenBackQ[ldqHead_i];
	assign replaySize_o = sizeQ[ldqHead_i];

endmodule

//--- design/ldqViolationDetect.sv
// store-to-load ordering violation check
// builds the window of loads younger than the store, matches addresses
// by the wider access size and picks the first violator from nextLoad
`timescale 1ns/1ps

module ldqViolationDetect
#(
	parameter int lsqDepth = lsqGeometryPkg::defaultLsqDepth,
	localparam int idxWidth = (lsqDepth > 1) ? $clog2(lsqDepth) : 1,
	localparam int cntWidth = $clog2(lsqDepth + 1)
)
(
	input  logic                     stValid_i,
	input  memAccessPkg::accessSizeT stSize_i,
	input  logic [idxWidth-1:0]      nextLoad_i,

	input  logic [idxWidth-1:0]      ldqHead_i,
	input  logic [idxWidth-1:0]      ldqTail_i,
	input  logic [cntWidth-1:0]      ldqCount_i,

	input  logic [lsqDepth-1:0]      wordHit_i,
	input  logic [lsqDepth-1:0]      halfHit_i,
	input  logic [lsqDepth-1:0]      byteHit_i,

	input  logic [lsqDepth-1:0]      addrValid_i,
	input  logic [lsqDepth-1:0]      writtenBack_i,
	input  memAccessPkg::accessSizeT entrySize_i [lsqDepth],

	output logic [idxWidth-1:0]      firstMatch_o,
	output logic                     vioValid_o
);

	logic [lsqDepth-1:0] windowVec;
	logic [lsqDepth-1:0] matchVec;
	logic [lsqDepth-1:0] violateVec;

	// window of loads after the store, tail excluded
	always_comb
	begin : windowBuild
		logic wraps;
		logic fullQueue;

		wraps = (ldqTail_i < nextLoad_i);
		// all three pointers equal with loads present means every entry counts
		fullQueue = (ldqTail_i == nextLoad_i) && (ldqHead_i == nextLoad_i) &&
			(ldqCount_i != '0);

		for (int i = 0; i < lsqDepth; i++)
		begin
			if (fullQueue)
			begin
				windowVec[i] = 1'b1;
			end
			else if (wraps)
			begin
				windowVec[i] = (i >= int'(nextLoad_i)) || (i < int'(ldqTail_i));
			end
			else
			begin
				windowVec[i] = (i >= int'(nextLoad_i)) && (i < int'(ldqTail_i));
			end
		end
	end

	// overlap judged at the wider of the two sizes
	always_comb
	begin : sizeMatch
		memAccessPkg::accessSizeT maxSize;

		for (int i = 0; i < lsqDepth; i++)
		begin
			maxSize = (stSize_i > entrySize_i[i]) ? stSize_i : entrySize_i[i];
			case (maxSize)
				memAccessPkg::accessByte:
				begin
					matchVec[i] = wordHit_i[i] & halfHit_i[i] & byteHit_i[i];
				end
				memAccessPkg::accessHalf:
				begin
					matchVec[i] = wordHit_i[i] & halfHit_i[i];
				end
				default:
				begin
					matchVec[i] = wordHit_i[i];
				end
			endcase
		end
	end

	// only loads that already read their data can be wrong
	assign violateVec = {lsqDepth{stValid_i}} & windowVec & matchVec &
		addrValid_i & writtenBack_i;

	// first set bit scanning from nextLoad, wrap by hand for odd depths
	always_comb
	begin : firstScan
		int idx;
		logic found;

		found = 1'b0;
		firstMatch_o = '0;
		for (int i = 0; i < lsqDepth; i++)
		begin
			idx = int'(nextLoad_i) + i;
			if (idx >= lsqDepth)
			begin
				idx = idx - lsqDepth;
			end
			if (violateVec[idx] && !found)
			begin
				found = 1'b1;
				firstMatch_o = idxWidth'(idx);
			end
		end
		vioValid_o = found;
	end

endmodule

//--- design/stxPath.sv
// store execute path of the load queue
// keeps executed load state, offers the head load for replay and flags
// the first younger load that a store's bytes overlap
`timescale 1ns/1ps

module stxPath
#(
	parameter int lsqDepth = lsqGeometryPkg::defaultLsqDepth,
	parameter int dispatchWidth = lsqGeometryPkg::defaultDispatchWidth,
	parameter int commitWidth = lsqGeometryPkg::defaultCommitWidth,
	localparam int idxWidth = (lsqDepth > 1) ? $clog2(lsqDepth) : 1,
	localparam int cntWidth = $clog2(lsqDepth + 1),
	localparam int commitCntWidth = $clog2(commitWidth + 1)
)
(
	input  logic clk,
	input  logic reset,
	input  logic recoverFlag_i,

	// dispatch lanes
	input  logic                     dispatchReady_i,
	input  logic [dispatchWidth-1:0] dispLoad_i,
	input  logic [dispatchWidth-1:0] dispStore_i,
	input  logic [idxWidth-1:0]      dispLdId_i   [dispatchWidth],
	input  logic [idxWidth-1:0]      dispStId_i   [dispatchWidth],
	input  logic [idxWidth-1:0]      dispNextLd_i [dispatchWidth],

	// load execute
	input  logic                                    ldValid_i,
	input  logic [idxWidth-1:0]                     ldLsqId_i,
	input  logic [lsqGeometryPkg::virtAddrWidth-1:0] ldAddr_i,
	input  memAccessPkg::accessSizeT                ldSize_i,
	input  logic [lsqGeometryPkg::phyRegWidth-1:0]  ldPhyDest_i,
	input  logic [lsqGeometryPkg::alIdWidth-1:0]    ldAlId_i,
	input  logic                                    loadDataValid_i,

	// store execute probe
	input  logic                                    stValid_i,
	input  logic [idxWidth-1:0]                     stLsqId_i,
	input  logic [lsqGeometryPkg::virtAddrWidth-1:0] stAddr_i,
	input  memAccessPkg::accessSizeT                stSize_i,

	// queue pointers
	input  logic [idxWidth-1:0] ldqHead_i,
	input  logic [idxWidth-1:0] ldqTail_i,
	input  logic [cntWidth-1:0] ldqCount_i,

	// commit
	input  logic [commitCntWidth-1:0] commitLdCount_i,
	input  logic [idxWidth-1:0]       commitLdIndex_i [commitWidth],

	// replay of the head load
	output logic                                    replayValid_o,
	output logic [idxWidth-1:0]                     replayLsqId_o,
	output logic [lsqGeometryPkg::virtAddrWidth-1:0] replayAddr_o,
	output logic [lsqGeometryPkg::phyRegWidth-1:0]  replayPhyDest_o,
	output logic [lsqGeometryPkg::alIdWidth-1:0]    replayAlId_o,
	output memAccessPkg::accessSizeT                replaySize_o,

	// ordering violation
	output logic                                    vioValid_o,
	output logic [lsqGeometryPkg::alIdWidth-1:0]    vioAlId_o
);

	localparam int wordTagWidth = lsqGeometryPkg::virtAddrWidth -
		lsqGeometryPkg::byteOffsetWidth;

	logic [lsqDepth-1:0] wordHit;
	logic [lsqDepth-1:0] halfHit;
	logic [lsqDepth-1:0] byteHit;
	logic [lsqDepth-1:0] addrValid;
	logic [lsqDepth-1:0] writtenBack;
	memAccessPkg::accessSizeT entrySize [lsqDepth];
	logic [idxWidth-1:0] firstMatch;

	// payload ports, read 0 is the head and read 1 the violator
	logic [idxWidth-1:0]      payRdIdx  [2];
	memAccessPkg::ldPayloadT  payRdData [2];
	logic [idxWidth-1:0]      payWrIdx  [1];
	memAccessPkg::ldPayloadT  payWrData [1];

	// next-load index per store entry
	logic [idxWidth-1:0] nextLdRdIdx  [1];
	logic [idxWidth-1:0] nextLdRdData [1];

	// word part of the address
	loadAddrCam #(.lsqDepth(lsqDepth), .tagWidth(wordTagWidth)) wordCam
	(
		.clk        (clk),
		.we_i       (ldValid_i),
		.wrIdx_i    (ldLsqId_i),
		.wrTag_i    (ldAddr_i[lsqGeometryPkg::virtAddrWidth-1:lsqGeometryPkg::byteOffsetWidth]),
		.matchTag_i (stAddr_i[lsqGeometryPkg::virtAddrWidth-1:lsqGeometryPkg::byteOffsetWidth]),
		.hit_o      (wordHit)
	);

	// half-word select, address bit 1
	loadAddrCam #(.lsqDepth(lsqDepth), .tagWidth(1)) halfCam
	(
		.clk        (clk),
		.we_i       (ldValid_i),
		.wrIdx_i    (ldLsqId_i),
		.wrTag_i    (ldAddr_i[1]),
		.matchTag_i (stAddr_i[1]),
		.hit_o      (halfHit)
	);

	// byte select, address bit 0
	loadAddrCam #(.lsqDepth(lsqDepth), .tagWidth(1)) byteCam
	(
		.clk        (clk),
		.we_i       (ldValid_i),
		.wrIdx_i    (ldLsqId_i),
		.wrTag_i    (ldAddr_i[0]),
		.matchTag_i (stAddr_i[0]),
		.hit_o      (byteHit)
	);

	assign payRdIdx[0] = ldqHead_i;
	assign payRdIdx[1] = firstMatch;
	assign payWrIdx[0] = ldLsqId_i;
	assign payWrData[0] = '{phyDest: ldPhyDest_i, alId: ldAlId_i, addr: ldAddr_i};

	ldqRegFile #(
		.entryT   (memAccessPkg::ldPayloadT),
		.lsqDepth (lsqDepth),
		.numRead  (2),
		.numWrite (1)
	) payloadRf
	(
		.clk      (clk),
		.rdIdx_i  (payRdIdx),
		.rdData_o (payRdData),
		.we_i     (ldValid_i),
		.wrIdx_i  (payWrIdx),
		.wrData_i (payWrData)
	);

	assign nextLdRdIdx[0] = stLsqId_i;

	// written by stores at dispatch
	ldqRegFile #(
		.entryT   (logic [idxWidth-1:0]),
		.lsqDepth (lsqDepth),
		.numRead  (1),
		.numWrite (dispatchWidth)
	) nextLdRf
	(
		.clk      (clk),
		.rdIdx_i  (nextLdRdIdx),
		.rdData_o (nextLdRdData),
		.we_i     (dispStore_i & {dispatchWidth{dispatchReady_i}}),
		.wrIdx_i  (dispStId_i),
		.wrData_i (dispNextLd_i)
	);

	ldqStatus #(
		.lsqDepth      (lsqDepth),
		.dispatchWidth (dispatchWidth),
		.commitWidth   (commitWidth)
	) status
	(
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag_i),
		.ldValid_i       (ldValid_i),
		.ldLsqId_i       (ldLsqId_i),
		.ldSize_i        (ldSize_i),
		.loadDataValid_i (loadDataValid_i),
		.dispatchReady_i (dispatchReady_i),
		.dispLoad_i      (dispLoad_i),
		.dispLdId_i      (dispLdId_i),
		.commitLdCount_i (commitLdCount_i),
		.commitLdIndex_i (commitLdIndex_i),
		.ldqHead_i       (ldqHead_i),
		.addrValid_o     (addrValid),
		.writtenBack_o   (writtenBack),
		.entrySize_o     (entrySize),
		.replayValid_o   (replayValid_o),
		.replaySize_o    (replaySize_o)
	);

	ldqViolationDetect #(.lsqDepth(lsqDepth)) vioDetect
	(
		.stValid_i     (stValid_i),
		.stSize_i      (stSize_i),
		.nextLoad_i    (nextLdRdData[0]),
		.ldqHead_i     (ldqHead_i),
		.ldqTail_i     (ldqTail_i),
		.ldqCount_i    (ldqCount_i),
		.wordHit_i     (wordHit),
		.halfHit_i     (halfHit),
		.byteHit_i     (byteHit),
		.addrValid_i   (addrValid),
		.writtenBack_i (writtenBack),
		.entrySize_i   (entrySize),
		.firstMatch_o  (firstMatch),
		.vioValid_o    (vioValid_o)
	);

	// replay always comes from the head
	assign replayLsqId_o = ldqHead_i;
	assign replayAddr_o = payRdData[0].addr;
	assign replayPhyDest_o = payRdData[0].phyDest;
	assign replayAlId_o = payRdData[0].alId;
	assign vioAlId_o = payRdData[1].alId;

endmodule

//--- verification/stxPathModel.svh
// reference model for the store execute path
// mirrors per-entry state, payloads and next-load indices and works out
// the replay and violation outputs that the DUT should show
`ifndef STX_PATH_MODEL_SVH
`define STX_PATH_MODEL_SVH

// entry state as seen after the last edge
logic mValid [depth];
logic mWb [depth];
memAccessPkg::accessSizeT mSize [depth];

// payload of the last load executed into each entry
logic [addrW-1:0] mAddr [depth];
logic [phyW-1:0] mPhyDest [depth];
logic [alW-1:0] mAlId [depth];

// next-load index per store entry
int mNextLd [depth];

task automatic modelClear();
	for (int i = 0; i < depth; i++)
	begin
		mValid[i] = 1'b0;
		mWb[i] = 1'b0;
		mSize[i] = memAccessPkg::accessByte;
	end
endtask

// one rising edge, using the inputs held during the cycle before it
task automatic modelEdge();
	if (recoverFlag)
	begin
		modelClear();
	end
	else
	begin
		if (ldValid)
		begin
			mValid[ldLsqId] = 1'b1;
			mWb[ldLsqId] = loadDataValid;
			mSize[ldLsqId] = ldSize;
		end
		// clears come last so they beat the execute set
		if (dispatchReady)
		begin
			for (int k = 0; k < dispW; k++)
			begin
				if (dispLoad[k])
				begin
					mValid[dispLdId[k]] = 1'b0;
					mWb[dispLdId[k]] = 1'b0;
				end
			end
		end
		for (int c = 0; c < int'(commitLdCount); c++)
		begin
			mValid[commitLdIndex[c]] = 1'b0;
			mWb[commitLdIndex[c]] = 1'b0;
		end
	end

	// storage without reset, written whatever the status does
	if (ldValid)
	begin
		mAddr[ldLsqId] = ldAddr;
		mPhyDest[ldLsqId] = ldPhyDest;
		mAlId[ldLsqId] = ldAlId;
	end
	// lanes in order, higher lane wins
	if (dispatchReady)
	begin
		for (int k = 0; k < dispW; k++)
		begin
			if (dispStore[k])
			begin
				mNextLd[dispStId[k]] = int'(dispNextLd[k]);
			end
		end
	end
endtask

function automatic logic expReplayValid(input int head);
	return mValid[head] && !mWb[head];
endfunction

// size code is log2 of the byte count, so align both to the wider one
function automatic logic bytesOverlap(input logic [addrW-1:0] ldA,
	input memAccessPkg::accessSizeT ldS, input logic [addrW-1:0] stA,
	input memAccessPkg::accessSizeT stS);
	int shift;
	shift = (int'(ldS) > int'(stS)) ? int'(ldS) : int'(stS);
	return (ldA >> shift) == (stA >> shift);
endfunction

// index of the first violating load from nextLoad, -1 when none
function automatic int expViolator(input logic stV, input int stId,
	input logic [addrW-1:0] stA, input memAccessPkg::accessSizeT stS,
	input int head, input int tail, input int count);
	int nl;
	int span;
	int idx;
	if (!stV)
	begin
		return -1;
	end
	nl = mNextLd[stId];
	// equal pointers with loads present cover the whole queue
	if (tail == head && head == nl && count != 0)
	begin
		span = depth;
	end
	else
	begin
		span = (tail - nl + depth) % depth;
	end
	for (int i = 0; i < span; i++)
	begin
		idx = (nl + i) % depth;
		if (mValid[idx] && mWb[idx] && bytesOverlap(mAddr[idx], mSize[idx], stA, stS))
		begin
			return idx;
		end
	end
	return -1;
endfunction

`endif

//--- verification/stxPathTb.sv
// testbench for the store execute path
// drives load execute, store probes, dispatch, commit and recovery,
// and compares every cycle against the reference model
`timescale 1ns/1ps

module stxPathTb;

	localparam int depth = lsqGeometryPkg::defaultLsqDepth;
	localparam int dispW = lsqGeometryPkg::defaultDispatchWidth;
	localparam int commitW = lsqGeometryPkg::defaultCommitWidth;
	localparam int idxW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);
	localparam int commitCntW = $clog2(commitW + 1);
	localparam int addrW = lsqGeometryPkg::virtAddrWidth;
	localparam int phyW = lsqGeometryPkg::phyRegWidth;
	localparam int alW = lsqGeometryPkg::alIdWidth;
	localparam int resetCycles = 8;
	// five tests of at most 150 cycles plus reset, with margin
	localparam int cycleLimit = 1000;

	logic clk;
	logic reset;
	logic recoverFlag;

	logic dispatchReady;
	logic [dispW-1:0] dispLoad;
	logic [dispW-1:0] dispStore;
	logic [idxW-1:0] dispLdId [dispW];
	logic [idxW-1:0] dispStId [dispW];
	logic [idxW-1:0] dispNextLd [dispW];

	logic ldValid;
	logic [idxW-1:0] ldLsqId;
	logic [addrW-1:0] ldAddr;
	memAccessPkg::accessSizeT ldSize;
	logic [phyW-1:0] ldPhyDest;
	logic [alW-1:0] ldAlId;
	logic loadDataValid;

	logic stValid;
	logic [idxW-1:0] stLsqId;
	logic [addrW-1:0] stAddr;
	memAccessPkg::accessSizeT stSize;

	logic [idxW-1:0] ldqHead;
	logic [idxW-1:0] ldqTail;
	logic [cntW-1:0] ldqCount;
	logic [commitCntW-1:0] commitLdCount;
	logic [idxW-1:0] commitLdIndex [commitW];

	logic replayValid;
	logic [idxW-1:0] replayLsqId;
	logic [addrW-1:0] replayAddr;
	logic [phyW-1:0] replayPhyDest;
	logic [alW-1:0] replayAlId;
	memAccessPkg::accessSizeT replaySize;
	logic vioValid;
	logic [alW-1:0] vioAlId;

	int seed = 98;
	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int testNum = 0;
	int testsFailed = 0;
	int testErrBase = 0;
	string testName;

	`include "stxPathModel.svh"

	stxPath #(
		.lsqDepth      (depth),
		.dispatchWidth (dispW),
		.commitWidth   (commitW)
	) UUT
	(
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag),
		.dispatchReady_i (dispatchReady),
		.dispLoad_i      (dispLoad),
		.dispStore_i     (dispStore),
		.dispLdId_i      (dispLdId),
		.dispStId_i      (dispStId),
		.dispNextLd_i    (dispNextLd),
		.ldValid_i       (ldValid),
		.ldLsqId_i       (ldLsqId),
		.ldAddr_i        (ldAddr),
		.ldSize_i        (ldSize),
		.ldPhyDest_i     (ldPhyDest),
		.ldAlId_i        (ldAlId),
		.loadDataValid_i (loadDataValid),
		.stValid_i       (stValid),
		.stLsqId_i       (stLsqId),
		.stAddr_i        (stAddr),
		.stSize_i        (stSize),
		.ldqHead_i       (ldqHead),
		.ldqTail_i       (ldqTail),
		.ldqCount_i      (ldqCount),
		.commitLdCount_i (commitLdCount),
		.commitLdIndex_i (commitLdIndex),
		.replayValid_o   (replayValid),
		.replayLsqId_o   (replayLsqId),
		.replayAddr_o    (replayAddr),
		.replayPhyDest_o (replayPhyDest),
		.replayAlId_o    (replayAlId),
		.replaySize_o    (replaySize),
		.vioValid_o      (vioValid),
		.vioAlId_o       (vioAlId)
	);

	// 100 ns period
	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("run stopped after %0d cycles without reaching the end", cycleCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// model follows the same edge as the DUT
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			modelClear();
		end
		else
		begin
			modelEdge();
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expV,
		input logic [31:0] actV);
		checkCount++;
		assert (actV === expV)
		else
		begin
			errCount++;
			$display("ERROR: %s expected 0x%h got 0x%h at cycle %0d", name, expV, actV,
				cycleCount);
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			runChecks();
		end
	end

	task automatic runChecks();
		logic rv;
		int vio;
		rv = expReplayValid(int'(ldqHead));
		vio = expViolator(stValid, int'(stLsqId), stAddr, stSize, int'(ldqHead),
			int'(ldqTail), int'(ldqCount));
		checkValue("replayValid_o", 32'(rv), 32'(replayValid));
		checkValue("replayLsqId_o", 32'(ldqHead), 32'(replayLsqId));
		if (rv)
		begin
			checkValue("replayAddr_o", 32'(mAddr[ldqHead]), 32'(replayAddr));
			checkValue("replayPhyDest_o", 32'(mPhyDest[ldqHead]), 32'(replayPhyDest));
			checkValue("replayAlId_o", 32'(mAlId[ldqHead]), 32'(replayAlId));
			checkValue("replaySize_o", 32'(mSize[ldqHead]), 32'(replaySize));
		end
		checkValue("vioValid_o", 32'(vio >= 0), 32'(vioValid));
		if (vio >= 0)
		begin
			checkValue("vioAlId_o", 32'(mAlId[vio]), 32'(vioAlId));
		end
	endtask

	// scenario intent, checked directly against the outputs
	task automatic expectReplay(input bit want);
		@(negedge clk);
		checkValue("replayValid_o", 32'(want), 32'(replayValid));
	endtask

	task automatic expectViolation(input bit want, input int al);
		@(negedge clk);
		checkValue("vioValid_o", 32'(want), 32'(vioValid));
		if (want)
		begin
			checkValue("vioAlId_o", 32'(al), 32'(vioAlId));
		end
	endtask

	function automatic logic [addrW-1:0] randomWord();
		logic [addrW-1:0] r;
		r = addrW'($random(seed));
		return r & ~addrW'(3);
	endfunction

	function automatic int randomId();
		int r;
		r = $random(seed);
		return r & ((1 << alW) - 1);
	endfunction

	task automatic initInputs();
		clk = 1'b0;
		reset = 1'b1;
		recoverFlag = 1'b0;
		dispatchReady = 1'b0;
		dispLoad = '0;
		dispStore = '0;
		for (int k = 0; k < dispW; k++)
		begin
			dispLdId[k] = '0;
			dispStId[k] = '0;
			dispNextLd[k] = '0;
		end
		ldValid = 1'b0;
		ldLsqId = '0;
		ldAddr = '0;
		ldSize = memAccessPkg::accessByte;
		ldPhyDest = '0;
		ldAlId = '0;
		loadDataValid = 1'b0;
		stValid = 1'b0;
		stLsqId = '0;
		stAddr = '0;
		stSize = memAccessPkg::accessByte;
		ldqHead = '0;
		ldqTail = '0;
		ldqCount = '0;
		commitLdCount = '0;
		for (int c = 0; c < commitW; c++)
		begin
			commitLdIndex[c] = '0;
		end
	endtask

	// strobes drop each cycle, pointers hold
	task automatic nextCycle();
		@(posedge clk);
		recoverFlag <= 1'b0;
		dispatchReady <= 1'b0;
		dispLoad <= '0;
		dispStore <= '0;
		ldValid <= 1'b0;
		loadDataValid <= 1'b0;
		stValid <= 1'b0;
		commitLdCount <= '0;
	endtask

	task automatic driveLoad(input int id, input logic [addrW-1:0] addr,
		input memAccessPkg::accessSizeT size, input int al, input bit withData);
		ldValid <= 1'b1;
		ldLsqId <= idxW'(id);
		ldAddr <= addr;
		ldSize <= size;
		ldPhyDest <= phyW'(randomId());
		ldAlId <= alW'(al);
		loadDataValid <= withData;
	endtask

	task automatic driveStore(input int stId, input logic [addrW-1:0] addr,
		input memAccessPkg::accessSizeT size);
		stValid <= 1'b1;
		stLsqId <= idxW'(stId);
		stAddr <= addr;
		stSize <= size;
	endtask

	task automatic driveDispLoad(input int lane, input int id);
		dispatchReady <= 1'b1;
		dispLoad[lane] <= 1'b1;
		dispLdId[lane] <= idxW'(id);
	endtask

	task automatic driveDispStore(input int lane, input int stId, input int nextLd);
		dispatchReady <= 1'b1;
		dispStore[lane] <= 1'b1;
		dispStId[lane] <= idxW'(stId);
		dispNextLd[lane] <= idxW'(nextLd);
	endtask

	task automatic driveCommit(input int count, input int i0, input int i1);
		commitLdCount <= commitCntW'(count);
		commitLdIndex[0] <= idxW'(i0);
		commitLdIndex[1] <= idxW'(i1);
	endtask

	task automatic setPointers(input int head, input int tail, input int count);
		ldqHead <= idxW'(head);
		ldqTail <= idxW'(tail);
		ldqCount <= cntW'(count);
	endtask

	task automatic beginTest(input string name);
		testNum++;
		testName = name;
		testErrBase = errCount;
	endtask

	task automatic endTest();
		int errs;
		errs = errCount - testErrBase;
		if (errs != 0)
		begin
			testsFailed++;
		end
		$display("test %0d %s: %s, %0d errors", testNum, testName,
			(errs == 0) ? "passed" : "failed", errs);
	endtask

	task automatic testReplay();
		logic [addrW-1:0] a;
		a = randomWord();
		beginTest("head replay");
		nextCycle();
		setPointers(3, 6, 3);
		driveLoad(3, a | 2, memAccessPkg::accessHalf, randomId(), 1'b0);
		nextCycle();
		expectReplay(1'b1);
		// same load again, this time with its data
		nextCycle();
		driveLoad(3, a, memAccessPkg::accessWord, randomId(), 1'b1);
		nextCycle();
		expectReplay(1'b0);
		nextCycle();
		driveLoad(4, a + 4, memAccessPkg::accessByte, randomId(), 1'b0);
		setPointers(4, 6, 2);
		nextCycle();
		expectReplay(1'b1);
		endTest();
	endtask

	task automatic testClear();
		logic [addrW-1:0] a;
		int al [5];
		a = randomWord();
		beginTest("dispatch and commit clear");
		nextCycle();
		setPointers(5, 10, 5);
		driveDispStore(0, 0, 5);
		for (int i = 0; i < 4; i++)
		begin
			al[i] = randomId();
			nextCycle();
			driveLoad(5 + i, a, memAccessPkg::accessWord, al[i], 1'b1);
		end
		nextCycle();
		driveStore(0, a, memAccessPkg::accessWord);
		expectViolation(1'b1, al[0]);
		nextCycle();
		driveDispLoad(0, 5);
		nextCycle();
		driveStore(0, a, memAccessPkg::accessWord);
		expectViolation(1'b1, al[1]);
		nextCycle();
		driveCommit(2, 6, 7);
		nextCycle();
		driveStore(0, a, memAccessPkg::accessWord);
		expectViolation(1'b1, al[3]);
		nextCycle();
		driveCommit(1, 8, 0);
		nextCycle();
		driveStore(0, a, memAccessPkg::accessWord);
		expectViolation(1'b0, 0);
		// replay goes away once its entry retires, even with a same-cycle execute
		nextCycle();
		setPointers(9, 10, 1);
		driveLoad(9, a, memAccessPkg::accessWord, randomId(), 1'b0);
		nextCycle();
		expectReplay(1'b1);
		nextCycle();
		driveCommit(1, 9, 0);
		driveLoad(9, a, memAccessPkg::accessWord, randomId(), 1'b0);
		nextCycle();
		expectReplay(1'b0);
		nextCycle();
		driveDispLoad(1, 9);
		driveLoad(9, a, memAccessPkg::accessWord, randomId(), 1'b0);
		nextCycle();
		expectReplay(1'b0);
		endTest();
	endtask

	task automatic testOverlap();
		logic [addrW-1:0] a;
		int al1;
		int al3;
		a = randomWord();
		al1 = randomId();
		al3 = randomId();
		beginTest("size-aware overlap");
		nextCycle();
		recoverFlag <= 1'b1;
		setPointers(0, 8, 8);
		nextCycle();
		driveDispStore(1, 2, 1);
		driveLoad(1, a, memAccessPkg::accessWord, al1, 1'b1);
		nextCycle();
		driveStore(2, a + 2, memAccessPkg::accessByte);
		expectViolation(1'b1, al1);
		nextCycle();
		driveStore(2, a + 4, memAccessPkg::accessByte);
		expectViolation(1'b0, 0);
		// narrow the load to a single byte
		nextCycle();
		driveLoad(1, a, memAccessPkg::accessByte, al1, 1'b1);
		nextCycle();
		driveStore(2, a + 1, memAccessPkg::accessByte);
		expectViolation(1'b0, 0);
		nextCycle();
		driveStore(2, a, memAccessPkg::accessByte);
		expectViolation(1'b1, al1);
		nextCycle();
		driveStore(2, a, memAccessPkg::accessHalf);
		expectViolation(1'b1, al1);
		nextCycle();
		driveStore(2, a + 2, memAccessPkg::accessHalf);
		expectViolation(1'b0, 0);
		nextCycle();
		driveLoad(3, a + 2, memAccessPkg::accessHalf, al3, 1'b1);
		nextCycle();
		driveStore(2, a + 3, memAccessPkg::accessByte);
		expectViolation(1'b1, al3);
		nextCycle();
		driveStore(2, a + 1, memAccessPkg::accessByte);
		expectViolation(1'b0, 0);
		endTest();
	endtask

	task automatic testWindow();
		logic [addrW-1:0] a;
		int al [depth];
		int order [6] = '{13, 15, 1, 2, 14, 4};
		a = randomWord();
		beginTest("first in window");
		nextCycle();
		recoverFlag <= 1'b1;
		setPointers(12, 4, 8);
		nextCycle();
		driveDispStore(0, 5, 14);
		driveDispStore(1, 6, 0);
		// 14 stays without data, 4 sits at the tail
		for (int i = 0; i < 6; i++)
		begin
			al[order[i]] = randomId();
			nextCycle();
			driveLoad(order[i], a, memAccessPkg::accessWord, al[order[i]], order[i] != 14);
		end
		nextCycle();
		driveStore(5, a + 1, memAccessPkg::accessByte);
		expectViolation(1'b1, al[15]);
		nextCycle();
		driveStore(6, a, memAccessPkg::accessWord);
		expectViolation(1'b1, al[1]);
		nextCycle();
		driveCommit(1, 1, 0);
		nextCycle();
		driveStore(6, a, memAccessPkg::accessWord);
		expectViolation(1'b1, al[2]);
		// whole queue in the window, scan wraps past the end
		nextCycle();
		setPointers(8, 8, 16);
		driveDispStore(0, 7, 8);
		driveCommit(2, 13, 15);
		nextCycle();
		driveStore(7, a + 2, memAccessPkg::accessHalf);
		expectViolation(1'b1, al[2]);
		nextCycle();
		setPointers(8, 8, 0);
		driveStore(7, a, memAccessPkg::accessWord);
		expectViolation(1'b0, 0);
		endTest();
	endtask

	task automatic testRecovery();
		logic [addrW-1:0] a;
		int al3;
		a = randomWord();
		al3 = randomId();
		beginTest("recovery");
		nextCycle();
		setPointers(2, 6, 4);
		driveDispStore(0, 9, 2);
		driveLoad(2, a, memAccessPkg::accessWord, randomId(), 1'b0);
		nextCycle();
		driveLoad(3, a, memAccessPkg::accessWord, al3, 1'b1);
		nextCycle();
		driveStore(9, a, memAccessPkg::accessWord);
		expectReplay(1'b1);
		expectViolation(1'b1, al3);
		// recovery beats a load executing in the same cycle
		nextCycle();
		recoverFlag <= 1'b1;
		driveLoad(4, a, memAccessPkg::accessWord, randomId(), 1'b1);
		nextCycle();
		driveStore(9, a, memAccessPkg::accessWord);
		expectReplay(1'b0);
		expectViolation(1'b0, 0);
		nextCycle();
		driveLoad(2, a, memAccessPkg::accessWord, randomId(), 1'b0);
		nextCycle();
		expectReplay(1'b1);
		endTest();
	endtask

	initial
	begin
		initInputs();
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		testReplay();
		testClear();
		testOverlap();
		testWindow();
		testRecovery();
		nextCycle();
		$display("%0d tests run, %0d failed, %0d checks, %0d errors", testNum, testsFailed,
			checkCount, errCount);
		if (errCount == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verification
design/lsqGeometryPkg.sv
design/memAccessPkg.sv
design/loadAddrCam.sv
design/ldqRegFile.sv
design/ldqStatus.sv
design/ldqViolationDetect.sv
design/stxPath.sv
verification/stxPathTb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the store execute path testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module stxPathTb \
	-Mdir obj_dir \
	-o stxPathSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/stxPathSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
